/* hdl/bcd_to_bin.sv */
// iterative BCD to binary converter, one digit per cycle, msd first
`timescale 1ns/10ps
`default_nettype none

module bcd_to_bin import p10_pkg::*; (
  input  logic     clk,
  input  logic     fsm_rst,
  input  logic     start,
  input  dat_bcd_t bcd,
  output dat_bin_t bin,
  output logic     done
);

  dat_bcd_t sh;
  dat_bin_t acc;
  fld_len_t cnt;
  logic     busy;

  assign bin = acc;

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      busy <= 1'b0;
      done <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy <= 1'b1;
        cnt  <= '0;
      end else if (busy) begin
        cnt <= cnt + 1'b1;
        if (cnt == fld_len_t'(DAT_LEN-1)) begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      sh  <= bcd;
      acc <= '0;
    end else if (busy) begin
      acc <= (acc << 3) + (acc << 1) + dat_bin_t'(sh[DAT_LEN-1]);  // acc*10 + digit
      sh  <= {sh[DAT_LEN-2:0], 4'h0};
    end
  end

endmodule

`default_nettype wire

/* hdl/bin_to_bcd.sv */
// double-dabble binary to BCD converter, one bit per cycle
`timescale 1ns/10ps
`default_nettype none

module bin_to_bcd import p10_pkg::*; (
  input  logic     clk,
  input  logic     fsm_rst,
  input  logic     start,
  input  dat_bin_t bin,
  output dat_bcd_t bcd,
  output logic     done
);

  dat_bin_t sh;
  logic [4*DAT_LEN-1:0] acc;
  logic [4*DAT_LEN-1:0] adj;
  bit_idx_t cnt;
  logic busy;

  assign bcd = acc;

  // add three to every digit above four before the shift
  always_comb begin
    for (int i = 0; i < DAT_LEN; i++) begin
      adj[4*i +: 4] = (acc[4*i +: 4] > 4'd4) ? acc[4*i +: 4] + 4'd3 : acc[4*i +: 4];
    end
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      busy <= 1'b0;
      done <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy <= 1'b1;
        cnt  <= '0;
      end else if (busy) begin
        cnt <= cnt + 1'b1;
        if (cnt == bit_idx_t'(DAT_BITS-1)) begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      sh  <= bin;
      acc <= '0;
    end else if (busy) begin
      acc <= {adj[4*DAT_LEN-2:0], sh[DAT_BITS-1]};
      sh  <= sh << 1;
    end
  end

endmodule

`default_nettype wire

/* hdl/byte_fifo.sv */
// synchronous first-word fall-through byte fifo
`timescale 1ns/10ps
`default_nettype none

module byte_fifo import p10_pkg::*; (
  input  logic  clk,
  input  logic  fsm_rst,
  input  logic  wr,
  input  byte_t din,
  input  logic  rd,
  output byte_t dout,
  output logic  empty,
  output logic  full
);

  byte_t mem [FIFO_DEPTH];
  logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
  logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
  fifo_cnt_t cnt;
  logic push;
  logic pop;

  assign push  = wr && !full;  // write to a full fifo is dropped
  assign pop   = rd && !empty;
  assign empty = (cnt == '0);
  assign full  = (cnt == fifo_cnt_t'(FIFO_DEPTH));
  assign dout  = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= din;
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;  // depth is a power of two, pointers wrap
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   cnt <= cnt + 1'b1;
        2'b01:   cnt <= cnt - 1'b1;
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hdl/cmd_parser.sv */
// command parser, splits a request into kind, name and BCD digits and flags syntax errors
`timescale 1ns/10ps
`default_nettype none

module cmd_parser import p10_pkg::*; (
  input  logic      clk,
  input  logic      fsm_rst,
  input  logic      cmd_clear,
  input  byte_t     rx_byte,
  input  logic      rx_avail,
  output logic      rx_pop,
  output logic      req_valid,
  output cmd_kind_t cmd_kind,
  output prm_name_t prm_name,
  output dat_bcd_t  dat_bcd,
  output logic      parse_err_valid,
  output err_t      parse_err
);

  rx_state_t state;
  err_t      err;        // first error of the current command
  err_t      byte_err;
  err_t      first_err;
  cmd_name_t cmd_buf;
  fld_len_t  len;
  logic      is_digit;

  assign rx_pop   = rx_avail && (state != rx_wait);
  assign is_digit = (rx_byte >= "0") && (rx_byte <= "9");

  // error caused by the byte at the fifo head
  always_comb begin
    byte_err = err_none;
    case (state)
      rx_cmd: begin
        if (rx_byte == CMD_DLM) begin
          if (cmd_buf != CMD_SET_NAME && cmd_buf != CMD_GET_NAME) byte_err = err_cmd;
        end else if (rx_byte == DAT_DLM || len == fld_len_t'(CMD_LEN)) begin
          byte_err = err_cmd;  // no name, or too long
        end
      end
      rx_prm: begin
        if (rx_byte == PRM_DLM) begin
          if (cmd_kind == cmd_get) byte_err = err_dat;
        end else if (rx_byte == DAT_DLM) begin
          if (cmd_kind == cmd_set) byte_err = err_dat;  // set without a value
        end else if (len == fld_len_t'(PRM_LEN)) begin
          byte_err = err_prm;
        end
      end
      rx_dat: begin
        if (rx_byte == DAT_DLM) begin
          if (len == '0) byte_err = err_dat;
        end else if (!is_digit || len == fld_len_t'(DAT_LEN)) begin
          byte_err = err_dat;
        end
      end
      default: ;
    endcase
  end

  assign first_err = (err != err_none) ? err : byte_err;

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state           <= rx_idle;
      err             <= err_none;
      req_valid       <= 1'b0;
      parse_err_valid <= 1'b0;
    end else begin
      req_valid       <= 1'b0;
      parse_err_valid <= 1'b0;
      if (state == rx_wait) begin
        if (cmd_clear) state <= rx_idle;
      end else if (rx_pop) begin
        if (state != rx_idle && rx_byte == DAT_DLM) begin
          // end of request, report at the semicolon
          state           <= rx_wait;
          req_valid       <= (first_err == err_none);
          parse_err_valid <= (first_err != err_none);
          parse_err       <= first_err;
        end else begin
          if (state != rx_idle) err <= first_err;
          case (state)
            rx_idle: if (rx_byte == START_RX) begin
              state    <= rx_cmd;
              err      <= err_none;
              len      <= '0;
              cmd_buf  <= '0;
              prm_name <= '0;
              dat_bcd  <= '0;
            end
            rx_cmd: if (rx_byte == CMD_DLM) begin
              state    <= rx_prm;
              len      <= '0;
              cmd_kind <= (cmd_buf == CMD_GET_NAME) ? cmd_get : cmd_set;
            end else if (len != fld_len_t'(CMD_LEN)) begin
              cmd_buf <= {cmd_buf[CMD_LEN-2:0], rx_byte};
              len     <= len + 1'b1;
            end
            rx_prm: if (rx_byte == PRM_DLM) begin
              state <= rx_dat;
              len   <= '0;
            end else if (len != fld_len_t'(PRM_LEN)) begin
              prm_name <= {prm_name[PRM_LEN-2:0], rx_byte};
              len      <= len + 1'b1;
            end
            default: if (is_digit && len != fld_len_t'(DAT_LEN)) begin
              dat_bcd <= {dat_bcd[DAT_LEN-2:0], rx_byte[3:0]};
              len     <= len + 1'b1;
            end
          endcase
        end
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/p10_pkg.sv */
// p10 shared protocol constants, field widths, types, state encodings and parameter table
`default_nettype none

package p10_pkg;

  typedef logic [7:0] byte_t;
  typedef logic [3:0] bcd_t;

  // maximum field lengths in characters
  localparam int CMD_LEN = 4;
  localparam int PRM_LEN = 8;
  localparam int DAT_LEN = 8;
  localparam int DAT_BITS = 27;  // enough for 99999999
  localparam int TXT_LEN = 26;   // longest reply text

  typedef bcd_t [DAT_LEN-1:0] dat_bcd_t;
  typedef logic [DAT_BITS-1:0] dat_bin_t;
  typedef byte_t [PRM_LEN-1:0] prm_name_t;  // right-aligned, zero-padded
  typedef byte_t [CMD_LEN-1:0] cmd_name_t;
  typedef byte_t [TXT_LEN-1:0] txt_t;
  typedef logic [$clog2(PRM_LEN+1)-1:0] fld_len_t;
  typedef logic [$clog2(DAT_BITS)-1:0] bit_idx_t;
  typedef logic [$clog2(TXT_LEN)-1:0] txt_pos_t;

  localparam int FIFO_DEPTH = 8;
  typedef logic [$clog2(FIFO_DEPTH+1)-1:0] fifo_cnt_t;

  localparam int PRM_COUNT = 4;
  typedef logic [$clog2(PRM_COUNT)-1:0] prm_idx_t;

  ////////////////////////////////////////////////////////////
  // protocol characters
  ////////////////////////////////////////////////////////////
  localparam byte_t START_RX = 8'h60;  // backtick
  localparam byte_t START_TX = ">";
  localparam byte_t CMD_DLM  = "-";
  localparam byte_t PRM_DLM  = ":";
  localparam byte_t DAT_DLM  = ";";

  localparam cmd_name_t CMD_SET_NAME = cmd_name_t'("set");
  localparam cmd_name_t CMD_GET_NAME = cmd_name_t'("get");

  typedef enum logic {cmd_set, cmd_get} cmd_kind_t;

  typedef enum logic [2:0] {
    err_none, err_cmd, err_prm, err_dat,
    err_not_found, err_read_only, err_low, err_high
  } err_t;

  typedef enum logic [2:0] {rx_idle, rx_cmd, rx_prm, rx_dat, rx_wait} rx_state_t;
  typedef enum logic [2:0] {
    prm_idle, prm_scan, prm_conv, prm_check, prm_read, prm_done
  } prm_state_t;
  typedef enum logic [3:0] {
    tx_idle, tx_start, tx_name, tx_text, tx_colon, tx_dig, tx_stop, tx_cr, tx_lf
  } tx_state_t;

  ////////////////////////////////////////////////////////////
  // parameter table
  ////////////////////////////////////////////////////////////
  localparam prm_name_t PRM_NAMES [PRM_COUNT] = '{
    prm_name_t'("freq"), prm_name_t'("gain"), prm_name_t'("temp"), prm_name_t'("mode")
  };
  localparam dat_bin_t PRM_MIN  [PRM_COUNT] = '{27'd10, 27'd0, 27'd0, 27'd0};
  localparam dat_bin_t PRM_MAX  [PRM_COUNT] = '{27'd50000, 27'd255, 27'd0, 27'd3};
  localparam logic     PRM_RW   [PRM_COUNT] = '{1'b1, 1'b1, 1'b0, 1'b1};  // temp is read-only
  localparam dat_bin_t PRM_INIT [PRM_COUNT] = '{27'd1000, 27'd16, 27'd25, 27'd0};

endpackage

`default_nettype wire

/* hdl/p10_top.sv */
// p10 top level, byte fifos, credit handling and the command path
`timescale 1ns/10ps
`default_nettype none

module p10_top import p10_pkg::*; (
  input  logic  clk,
  input  logic  fsm_rst,
  input  byte_t rxd,
  input  logic  rxv,
  output logic  rx_credit,
  output byte_t txd,
  output logic  txv,
  input  logic  tx_credit
);

  byte_t     rx_byte;
  logic      rx_empty;
  logic      rx_full;
  logic      rx_pop;
  byte_t     tx_byte;
  logic      tx_wr;
  logic      tx_empty;
  logic      tx_full;
  logic [7:0] tx_cred;  // wider than the fifo, host may grant ahead
  logic      req_valid;
  cmd_kind_t cmd_kind;
  prm_name_t prm_name;
  dat_bcd_t  dat_bcd;
  logic      parse_err_valid;
  err_t      parse_err;
  logic      rsp_valid;
  err_t      rsp_err;
  dat_bcd_t  rsp_bcd;
  logic      cmd_clear;

  byte_fifo rx_fifo (
    .clk (clk), .fsm_rst (fsm_rst), .wr (rxv), .din (rxd),
    .rd (rx_pop), .dout (rx_byte), .empty (rx_empty), .full (rx_full)
  );

  byte_fifo tx_fifo (
    .clk (clk), .fsm_rst (fsm_rst), .wr (tx_wr), .din (tx_byte),
    .rd (txv), .dout (txd), .empty (tx_empty), .full (tx_full)
  );

  cmd_parser u_cmd_parser (
    .clk (clk), .fsm_rst (fsm_rst), .cmd_clear (cmd_clear),
    .rx_byte (rx_byte), .rx_avail (!rx_empty), .rx_pop (rx_pop),
    .req_valid (req_valid), .cmd_kind (cmd_kind), .prm_name (prm_name), .dat_bcd (dat_bcd),
    .parse_err_valid (parse_err_valid), .parse_err (parse_err)
  );

  prm_table u_prm_table (
    .clk (clk), .fsm_rst (fsm_rst), .cmd_clear (cmd_clear), .req_valid (req_valid),
    .cmd_kind (cmd_kind), .prm_name (prm_name), .dat_bcd (dat_bcd),
    .rsp_valid (rsp_valid), .rsp_err (rsp_err), .rsp_bcd (rsp_bcd)
  );

  rsp_builder u_rsp_builder (
    .clk (clk), .fsm_rst (fsm_rst),
    .parse_err_valid (parse_err_valid), .parse_err (parse_err),
    .rsp_valid (rsp_valid), .rsp_err (rsp_err), .rsp_bcd (rsp_bcd),
    .prm_name (prm_name), .cmd_kind (cmd_kind), .tx_full (tx_full),
    .tx_wr (tx_wr), .tx_byte (tx_byte), .cmd_clear (cmd_clear)
  );

  ////////////////////////////////////////////////////////////
  // credits
  ////////////////////////////////////////////////////////////
  assign txv = (tx_cred != '0) && !tx_empty;

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      tx_cred   <= '0;
      rx_credit <= 1'b0;
    end else begin
      rx_credit <= rx_pop;  // one credit back per consumed byte
      case ({tx_credit, txv})
        2'b10:   tx_cred <= tx_cred + 1'b1;
        2'b01:   tx_cred <= tx_cred - 1'b1;
        default: ;  // grant and send cancel out
      endcase
    end
  end

endmodule

`default_nettype wire

/* hdl/prm_table.sv */
// parameter table, name lookup, access and limit checks, and value RAM
`timescale 1ns/10ps
`default_nettype none

module prm_table import p10_pkg::*; (
  input  logic      clk,
  input  logic      fsm_rst,
  input  logic      cmd_clear,
  input  logic      req_valid,
  input  cmd_kind_t cmd_kind,
  input  prm_name_t prm_name,
  input  dat_bcd_t  dat_bcd,
  output logic      rsp_valid,
  output err_t      rsp_err,
  output dat_bcd_t  rsp_bcd
);

  dat_bin_t   ram [PRM_COUNT];
  prm_state_t state;
  prm_idx_t   idx;
  dat_bin_t   set_bin;
  logic       hit;
  logic       set_start;
  logic       set_done;
  logic       get_start;
  logic       get_done;

  assign hit       = (PRM_NAMES[idx] == prm_name);
  assign set_start = (state == prm_scan) && hit && (cmd_kind == cmd_set);
  assign get_start = (state == prm_scan) && hit && (cmd_kind == cmd_get);

  bcd_to_bin u_bcd_to_bin (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .start   (set_start),
    .bcd     (dat_bcd),
    .bin     (set_bin),
    .done    (set_done)
  );

  bin_to_bcd u_bin_to_bcd (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .start   (get_start),
    .bin     (ram[idx]),
    .bcd     (rsp_bcd),
    .done    (get_done)
  );

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state     <= prm_idle;
      rsp_valid <= 1'b0;
      ram       <= PRM_INIT;
    end else begin
      rsp_valid <= 1'b0;
      if (cmd_clear) begin
        state <= prm_idle;
      end else begin
        case (state)
          prm_idle: if (req_valid) begin
            idx   <= '0;
            state <= prm_scan;
          end
          prm_scan: if (hit) begin
            state <= (cmd_kind == cmd_set) ? prm_conv : prm_read;
          end else if (idx == prm_idx_t'(PRM_COUNT-1)) begin
            rsp_err   <= err_not_found;
            rsp_valid <= 1'b1;
            state     <= prm_done;
          end else begin
            idx <= idx + 1'b1;
          end
          prm_conv: if (set_done) state <= prm_check;
          prm_check: begin
            rsp_valid <= 1'b1;
            state     <= prm_done;
            if (!PRM_RW[idx]) rsp_err <= err_read_only;
            else if (set_bin < PRM_MIN[idx]) rsp_err <= err_low;
            else if (set_bin > PRM_MAX[idx]) rsp_err <= err_high;
            else begin
              rsp_err  <= err_none;
              ram[idx] <= set_bin;
            end
          end
          prm_read: if (get_done) begin
            rsp_err   <= err_none;
            rsp_valid <= 1'b1;
            state     <= prm_done;
          end
          default: ;  // hold until the reply is out
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/rsp_builder.sv */
// reply builder, formats the response and writes it byte by byte into the tx fifo
`timescale 1ns/10ps
`default_nettype none

module rsp_builder import p10_pkg::*; (
  input  logic      clk,
  input  logic      fsm_rst,
  input  logic      parse_err_valid,
  input  err_t      parse_err,
  input  logic      rsp_valid,
  input  err_t      rsp_err,
  input  dat_bcd_t  rsp_bcd,
  input  prm_name_t prm_name,
  input  cmd_kind_t cmd_kind,
  input  logic      tx_full,
  output logic      tx_wr,
  output byte_t     tx_byte,
  output logic      cmd_clear
);

  tx_state_t state;
  err_t      err;
  txt_t      str;   // name or text, sent from the top byte, zero bytes skipped
  dat_bcd_t  dig;
  txt_pos_t  pos;
  logic      lead;  // still inside the leading zeros
  logic      skip;
  logic      adv;

  // reply texts, right-aligned and zero-padded
  function automatic txt_t err_text(input err_t e);
    case (e)
      err_none:      return txt_t'(": parameter set");
      err_cmd:       return txt_t'("error: bad command");
      err_prm:       return txt_t'("error: bad parameter");
      err_dat:       return txt_t'("error: bad data");
      err_not_found: return txt_t'("error: parameter not found");
      err_read_only: return txt_t'("error: read-only");
      err_low:       return txt_t'("error: value too low");
      default:       return txt_t'("error: value too high");
    endcase
  endfunction

  always_comb begin
    tx_byte = 8'h00;
    skip    = 1'b0;
    case (state)
      tx_start: tx_byte = START_TX;
      tx_name, tx_text: begin
        tx_byte = str[pos];
        skip    = (str[pos] == 8'h00);  // zero padding
      end
      tx_colon: tx_byte = PRM_DLM;
      tx_dig: begin
        tx_byte = {4'h3, dig[DAT_LEN-1]};
        skip    = lead && (dig[DAT_LEN-1] == 4'h0) && (pos != '0);
      end
      tx_stop: tx_byte = DAT_DLM;
      tx_cr:   tx_byte = 8'h0d;
      tx_lf:   tx_byte = 8'h0a;
      default: ;
    endcase
  end

  assign adv   = (state != tx_idle) && (skip || !tx_full);
  assign tx_wr = (state != tx_idle) && !skip && !tx_full;

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state     <= tx_idle;
      cmd_clear <= 1'b0;
    end else begin
      cmd_clear <= 1'b0;
      case (state)
        tx_idle: if (parse_err_valid || rsp_valid) begin
          state <= tx_start;
          err   <= parse_err_valid ? parse_err : rsp_err;
          dig   <= rsp_bcd;
        end
        tx_start: if (adv) begin
          pos <= txt_pos_t'(TXT_LEN-1);
          if (err == err_none) begin
            state <= tx_name;
            str   <= txt_t'(prm_name);
          end else begin
            state <= tx_text;
            str   <= err_text(err);
          end
        end
        tx_name: if (adv) begin
          if (pos != '0) begin
            pos <= pos - 1'b1;
          end else if (cmd_kind == cmd_get) begin
            state <= tx_colon;
          end else begin
            state <= tx_text;
            str   <= err_text(err_none);
            pos   <= txt_pos_t'(TXT_LEN-1);
          end
        end
        tx_text: if (adv) begin
          if (pos != '0) pos <= pos - 1'b1;
          else state <= tx_stop;
        end
        tx_colon: if (adv) begin
          state <= tx_dig;
          pos   <= txt_pos_t'(DAT_LEN-1);
          lead  <= 1'b1;
        end
        tx_dig: if (adv) begin
          dig  <= {dig[DAT_LEN-2:0], 4'h0};
          lead <= skip;  // cleared by the first digit sent
          if (pos != '0) pos <= pos - 1'b1;
          else state <= tx_stop;
        end
        tx_stop: if (adv) state <= tx_cr;
        tx_cr:   if (adv) state <= tx_lf;
        tx_lf: if (adv) begin
          state     <= tx_idle;
          cmd_clear <= 1'b1;  // releases parser and table
        end
        default: state <= tx_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build and run the p10 regression with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f sources.f --top-module p10_tb -o p10_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi
./obj_dir/p10_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
fi
if grep -q "^Regression passed$" sim.log; then
  exit 0
fi
exit 1

/* sim/p10_assert.sv */
// credit and fifo rules of the p10 top level, bound into p10_top
`timescale 1ns/10ps
`default_nettype none

module p10_assert (
  input logic clk,
  input logic fsm_rst,
  input logic txv,
  input logic tx_credit,
  input logic rxv,
  input logic rx_full
);

  int granted;  // host grants not yet spent on a byte

  always_ff @(posedge clk) begin
    if (fsm_rst) granted <= 0;
    else granted <= granted + int'(tx_credit) - int'(txv);
  end

  // a byte leaves only against a granted credit
  a_tx_needs_credit: assert property (
    @(posedge clk) disable iff (fsm_rst) txv |-> (granted > 0))
    else $error("txv high with no tx credit");

  a_rx_no_overflow: assert property (@(posedge clk) disable iff (fsm_rst) !(rxv && rx_full))
    else $error("rx fifo written while full");

  a_tx_quiet_in_reset: assert property (@(posedge clk) fsm_rst |-> !txv)
    else $error("txv high during reset");

endmodule

bind p10_top p10_assert u_p10_assert (
  .clk (clk), .fsm_rst (fsm_rst), .txv (txv), .tx_credit (tx_credit), .rxv (rxv),
  .rx_full (rx_full)
);

`default_nettype wire

/* sim/p10_tb.sv */
// directed testbench for the p10 command interpreter, credit-aware host model and reply checks
`timescale 1ns/10ps
`default_nettype none

module p10_tb import p10_pkg::*; ();

  localparam int HALF = 20;        // 40 ns clock
  localparam int DRV = 2;          // drive delay after the rising edge
  localparam int WAIT_MAX = 3000;  // cycles per wait loop

  logic  clk;
  logic  fsm_rst;
  byte_t rxd;
  logic  rxv;
  logic  rx_credit;
  byte_t txd;
  logic  txv;
  logic  tx_credit;

  int    sent_cnt = 0;  // bytes pushed into the rx link
  int    ret_cnt = 0;   // rx credits handed back
  int    owed = 0;      // tx credits granted and not yet used
  int    lf_cnt = 0;
  byte_t rsp_q[$];
  byte_t line_q[$];
  string names[PRM_COUNT] = '{"freq", "gain", "temp", "mode"};
  int    model[PRM_COUNT];

  p10_top dut0 (
    .clk (clk), .fsm_rst (fsm_rst), .rxd (rxd), .rxv (rxv), .rx_credit (rx_credit),
    .txd (txd), .txv (txv), .tx_credit (tx_credit)
  );

  always #HALF clk = ~clk;

  // link monitor, every byte that leaves the tx fifo and every credit returned
  always @(posedge clk) begin
    if (!fsm_rst) begin
      if (txv) begin
        if (owed <= 0) abort_run("tx byte sent without a granted credit");
        rsp_q.push_back(txd);
        owed--;
        if (txd == 8'h0a) lf_cnt++;
      end
      if (rx_credit) begin
        if (ret_cnt >= sent_cnt) abort_run("rx credit returned for a byte never sent");
        ret_cnt++;
      end
    end
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_byte(input string sig, input byte_t got, input byte_t exp);
    if (got !== exp) abort_run($sformatf("MISMATCH %s got 0x%h expected 0x%h", sig, got, exp));
  endtask

  task automatic check_dat(input string sig, input dat_bin_t got, input dat_bin_t exp);
    if (got !== exp) abort_run($sformatf("MISMATCH %s got 0x%h expected 0x%h", sig, got, exp));
  endtask

  task automatic step();
    @(posedge clk);
    #DRV;
  endtask

  function automatic string req(input string body);
    return $sformatf("%c%s", 8'h60, body);  // backtick opens a request
  endfunction

  // one byte per cycle, only while a receive credit is held
  task automatic send_cmd(input string cmd);
    int waited;
    for (int i = 0; i < cmd.len(); i++) begin
      waited = 0;
      while (sent_cnt - ret_cnt >= FIFO_DEPTH) begin
        step();
        rxv = 1'b0;
        waited++;
        if (waited > WAIT_MAX) abort_run("timeout waiting for rx_credit");
      end
      step();
      rxd = cmd[i];
      rxv = 1'b1;
      sent_cnt++;
    end
    step();
    rxv = 1'b0;
  endtask

  // grant tx credits in random bursts until n more line feeds arrive
  task automatic get_reply(input int n, input int hold);
    int target;
    int waited;
    int burst;
    int pause;
    target = lf_cnt + n;
    waited = 0;
    burst = 0;
    pause = hold;  // no grants at all for the first hold cycles
    while (lf_cnt < target) begin
      step();
      tx_credit = 1'b0;
      waited++;
      if (waited > hold + n * WAIT_MAX) abort_run("timeout waiting for a reply line feed");
      if (pause > 0) begin
        pause--;
      end else if (burst == 0) begin
        burst = 1 + int'($urandom % 4);
        pause = int'($urandom % 5);
      end else if (owed < 3) begin
        tx_credit = 1'b1;
        owed++;
        burst--;
      end
    end
    step();
    tx_credit = 1'b0;
  endtask

  task automatic pop_line();
    byte_t b;
    line_q.delete();
    b = 8'h00;
    while (b != 8'h0a) begin
      if (rsp_q.size() == 0) abort_run("reply ended before its line feed");
      b = rsp_q.pop_front();
      line_q.push_back(b);
    end
  endtask

  task automatic match_line(input string body);
    if (line_q.size() != body.len() + 2)
      abort_run($sformatf("reply has %0d bytes, expected %0d", line_q.size(), body.len() + 2));
    for (int i = 0; i < body.len(); i++) check_byte("txd", line_q[i], body[i]);
    check_byte("txd", line_q[body.len()], 8'h0d);
    check_byte("txd", line_q[body.len() + 1], 8'h0a);
  endtask

  task automatic expect_line(input string body);
    pop_line();
    match_line(body);
  endtask

  // digits are read back from the reply itself
  task automatic expect_get(input int idx);
    int val;
    int i;
    pop_line();
    val = 0;
    i = names[idx].len() + 2;
    while (i < line_q.size() && line_q[i] >= "0" && line_q[i] <= "9") begin
      val = val * 10 + int'(line_q[i]) - 48;
      i++;
    end
    check_dat("value", dat_bin_t'(val), dat_bin_t'(model[idx]));
    match_line($sformatf(">%s:%0d;", names[idx], model[idx]));
  endtask

  task automatic expect_err(input err_t e);
    string txt;
    case (e)
      err_cmd:       txt = "bad command";
      err_prm:       txt = "bad parameter";
      err_dat:       txt = "bad data";
      err_not_found: txt = "parameter not found";
      err_read_only: txt = "read-only";
      err_low:       txt = "value too low";
      default:       txt = "value too high";
    endcase
    expect_line($sformatf(">error: %s;", txt));
  endtask

  task automatic do_get(input int idx);
    send_cmd(req($sformatf("get-%s;", names[idx])));
    get_reply(1, 0);
    expect_get(idx);
  endtask

  // the model only follows a set that is accepted
  task automatic do_set(input int idx, input int val, input err_t e);
    send_cmd(req($sformatf("set-%s:%0d;", names[idx], val)));
    get_reply(1, 0);
    if (e == err_none) begin
      model[idx] = val;
      expect_line($sformatf(">%s: parameter set;", names[idx]));
    end else begin
      expect_err(e);
    end
  endtask

  task automatic do_bad(input string cmd, input err_t e);
    send_cmd(cmd);
    get_reply(1, 0);
    expect_err(e);
  endtask

  task automatic test_reset_values();
    for (int i = 0; i < PRM_COUNT; i++) do_get(i);
  endtask

  task automatic test_good_sets();
    do_set(0, 10, err_none);
    do_get(0);
    do_set(0, 50000, err_none);
    do_get(0);
    do_set(1, 200, err_none);
    do_get(1);
    do_set(3, 3, err_none);
    do_get(3);
    send_cmd(req("set-gain:007;"));  // leading zeros on input
    get_reply(1, 0);
    model[1] = 7;
    expect_line(">gain: parameter set;");
    do_get(1);
  endtask

  task automatic test_limit_errors();
    do_set(0, 9, err_low);
    do_set(0, 50001, err_high);
    do_set(1, 256, err_high);
    do_set(2, 30, err_read_only);
    for (int i = 0; i < PRM_COUNT; i++) do_get(i);
  endtask

  task automatic test_syntax_errors();
    do_bad(req("put-freq;"), err_cmd);
    do_bad(req("gets-freq;"), err_cmd);
    do_get(0);
    do_bad(req("get-frequency;"), err_prm);
    do_bad(req("set-gain:1x;"), err_dat);
    do_bad(req("set-gain:123456789;"), err_dat);
    do_get(1);
    do_bad(req("get-volt;"), err_not_found);
    send_cmd({"xyz", req("get-mode;")});  // noise ahead of the start character
    get_reply(1, 0);
    expect_get(3);
  endtask

  task automatic test_back_to_back();
    int waited;
    fork
      begin
        send_cmd(req("set-gain:42;"));
        send_cmd(req("get-gain;"));
        send_cmd(req("set-mode:9;"));
        send_cmd(req("get-freq;"));
      end
      get_reply(4, 150);
    join
    model[1] = 42;
    expect_line(">gain: parameter set;");
    expect_get(1);
    expect_err(err_high);
    expect_get(0);
    waited = 0;
    while (ret_cnt != sent_cnt) begin
      step();
      waited++;
      if (waited > WAIT_MAX) abort_run("rx credits were not all returned");
    end
  endtask

  initial begin
    void'($urandom(80));
    clk = 1'b0;
    fsm_rst = 1'b1;
    rxd = '0;
    rxv = 1'b0;
    tx_credit = 1'b0;
    model = '{1000, 16, 25, 0};
    repeat (8) @(posedge clk);
    #DRV;
    fsm_rst = 1'b0;
    step();
    test_reset_values();
    test_good_sets();
    test_limit_errors();
    test_syntax_errors();
    test_back_to_back();
    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
hdl/p10_pkg.sv
hdl/byte_fifo.sv
hdl/cmd_parser.sv
hdl/bcd_to_bin.sv
hdl/bin_to_bcd.sv
hdl/prm_table.sv
hdl/rsp_builder.sv
hdl/p10_top.sv
sim/p10_assert.sv
sim/p10_tb.sv
